/* vlog.f */
hdl/pipeline_types.sv
hdl/predict_if.sv
hdl/update_if.sv
hdl/pc_reg.sv
hdl/bpu.sv
hdl/instbuffer.sv
hdl/frontend_top.sv
tb/tb_clock_gen.sv
tb/frontend_tb.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - hdl/pipeline_types.sv
  - hdl/predict_if.sv
  - hdl/update_if.sv
  - hdl/pc_reg.sv
  - hdl/bpu.sv
  - hdl/instbuffer.sv
  - hdl/frontend_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/frontend_tb.sv

/* tb/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb
    import pipeline_types::*;
();

    localparam int BTB_INDEX_BITS  = 4;
    localparam int BUF_DEPTH       = 8;
    localparam int BACKEND_CREDITS = 4;
    localparam int BTB_ENTRIES     = 1 << BTB_INDEX_BITS;
    localparam int CLK_PERIOD_NS   = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int TEST_CYCLES     = RESET_CYCLES + 150 + 800 + 60 + 200;
    localparam int WATCHDOG_NS     = 20 * TEST_CYCLES * CLK_PERIOD_NS;

    logic  clk, rst;
    addr_t fetch_pc;
    logic  fetch_req;
    inst_t icache_inst;
    logic  icache_valid, icache_stall;
    logic  upd_valid, upd_taken, flush;
    addr_t upd_pc, upd_target;
    logic  credit_return;
    logic  out_valid, out_pred_taken;
    addr_t out_pc, out_pred_target;
    inst_t out_inst;

    // Reference BTB
    logic     m_valid  [BTB_ENTRIES];
    addr_t    m_tag    [BTB_ENTRIES];
    addr_t    m_target [BTB_ENTRIES];
    counter_t m_ctr    [BTB_ENTRIES];

    // Fetches issued and not yet delivered, with the prediction at issue
    addr_t iss_pc     [$];
    logic  iss_taken  [$];
    addr_t iss_target [$];
    int    due_q      [$];

    int    cycle, mismatches, failures, delivered, outstanding, mark;
    logic  allow_upd, allow_flush, withhold, pend_valid;
    inst_t pend_inst;
    addr_t exp_out_pc, exp_fetch_pc;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clk_gen (.clk);

    frontend_top #(
        .BTB_INDEX_BITS  (BTB_INDEX_BITS),
        .BUF_DEPTH       (BUF_DEPTH),
        .BACKEND_CREDITS (BACKEND_CREDITS)
    ) frontend_top_i (.*);

    function automatic inst_t scramble_pc(addr_t pc);
        return {pc[15:0], pc[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic int btb_index(addr_t pc);
        return int'(pc[BTB_INDEX_BITS+1:2]);
    endfunction

    function automatic logic btb_hit(addr_t pc);
        return m_valid[btb_index(pc)] && (m_tag[btb_index(pc)] == (pc >> (BTB_INDEX_BITS + 2)));
    endfunction

    function automatic logic predicts_taken(addr_t pc);
        return btb_hit(pc) && (m_ctr[btb_index(pc)] >= 2'd2);
    endfunction

    task automatic flag_mismatch(string what, logic [31:0] got, logic [31:0] want);
        mismatches++;
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic report_failure(string what);
        failures++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic train_model(addr_t pc, logic taken, addr_t target);
        int i;
        i = btb_index(pc);
        if (taken) begin
            if (!btb_hit(pc)) begin
                m_ctr[i] = 2'd2;
            end else if (m_ctr[i] != 2'd3) begin
                m_ctr[i] = m_ctr[i] + 2'd1;
            end
            m_valid[i]  = 1'b1;
            m_tag[i]    = pc >> (BTB_INDEX_BITS + 2);
            m_target[i] = target;
        end else if (btb_hit(pc) && (m_ctr[i] != 2'd0)) begin
            m_ctr[i] = m_ctr[i] - 2'd1;
        end
    endtask

    //////////////////////////////
    // Backend side
    //////////////////////////////

    task automatic check_delivery();
        if (delivered == 0) begin
            assert (out_pc == PC_RESET) else flag_mismatch("first out_pc", out_pc, PC_RESET);
        end
        delivered++;
        outstanding++;
        due_q.push_back(cycle + int'($urandom_range(3)));
        assert (outstanding <= BACKEND_CREDITS)
            else report_failure("backend holds more entries than it has credits");
        assert (out_pc == exp_out_pc) else flag_mismatch("out_pc", out_pc, exp_out_pc);
        assert (out_inst == scramble_pc(exp_out_pc))
            else flag_mismatch("out_inst", out_inst, scramble_pc(exp_out_pc));
        if (iss_pc.size() == 0) begin
            report_failure("entry delivered with no fetch outstanding");
            exp_out_pc = exp_out_pc + 32'd4;
        end else begin
            assert (out_pc == iss_pc[0]) else flag_mismatch("issued pc", out_pc, iss_pc[0]);
            assert (out_pred_taken == iss_taken[0])
                else flag_mismatch("out_pred_taken", out_pred_taken, iss_taken[0]);
            if (iss_taken[0]) begin
                assert (out_pred_target == iss_target[0])
                    else flag_mismatch("out_pred_target", out_pred_target, iss_target[0]);
            end
            // Next delivery follows the prediction made at issue
            exp_out_pc = iss_taken[0] ? iss_target[0] : exp_out_pc + 32'd4;
            void'(iss_pc.pop_front());
            void'(iss_taken.pop_front());
            void'(iss_target.pop_front());
        end
    endtask

    //////////////////////////////
    // Per-cycle stimulus
    //////////////////////////////

    task automatic run_cycles(int n);
        logic  issue;
        addr_t pc_now;
        for (int c = 0; c < n; c++) begin
            @(negedge clk);
            cycle++;
            if (out_valid) begin
                check_delivery();
            end
            assert (fetch_pc == exp_fetch_pc) else flag_mismatch("fetch_pc", fetch_pc, exp_fetch_pc);

            // Cache answers the fetch issued one cycle earlier
            icache_valid  = pend_valid;
            icache_inst   = pend_inst;
            icache_stall  = ($urandom_range(9) == 0);
            credit_return = 1'b0;
            if (!withhold && (due_q.size() > 0) && (due_q[0] <= cycle)) begin
                credit_return = 1'b1;
                void'(due_q.pop_front());
                outstanding--;
            end
            flush      = allow_flush && ($urandom_range(31) == 0);
            upd_valid  = allow_upd && !flush && ($urandom_range(3) == 0);
            upd_pc     = (($urandom_range(7) == 0) ? 32'h0000_2000 : PC_RESET)
                         + ($urandom_range(15) << 2);
            upd_taken  = ($urandom_range(3) != 0);
            upd_target = PC_RESET + ($urandom_range(31) << 2);

            pc_now     = fetch_pc;
            issue      = fetch_req && !icache_stall;
            pend_valid = issue;
            pend_inst  = scramble_pc(pc_now);
            if (flush) begin
                // Everything fetched so far is dropped
                exp_fetch_pc = upd_target;
                exp_out_pc   = upd_target;
                iss_pc.delete();
                iss_taken.delete();
                iss_target.delete();
            end else if (issue) begin
                iss_pc.push_back(exp_fetch_pc);
                iss_taken.push_back(predicts_taken(exp_fetch_pc));
                iss_target.push_back(m_target[btb_index(exp_fetch_pc)]);
                exp_fetch_pc = predicts_taken(exp_fetch_pc) ? m_target[btb_index(exp_fetch_pc)]
                                                             : exp_fetch_pc + 32'd4;
            end
            if (upd_valid) begin
                train_model(upd_pc, upd_taken, upd_target);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h781959bc));
        rst = 1'b1;
        {icache_inst, icache_valid, icache_stall, credit_return} = '0;
        {upd_valid, upd_pc, upd_taken, upd_target, flush} = '0;
        {cycle, mismatches, failures, delivered, outstanding, mark} = '0;
        {allow_upd, allow_flush, withhold, pend_valid, pend_inst} = '0;
        exp_out_pc   = PC_RESET;
        exp_fetch_pc = PC_RESET;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_ctr[i]    = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (!fetch_req && !out_valid) else report_failure("fetch_req or out_valid high in reset");
        assert (fetch_pc == PC_RESET) else flag_mismatch("reset fetch_pc", fetch_pc, PC_RESET);
        rst = 1'b0;

        // Sequential fetch with an empty BTB
        run_cycles(150);
        // Training, predictions and redirects
        allow_upd   = 1'b1;
        allow_flush = 1'b1;
        run_cycles(800);
        // Backend keeps its credits
        allow_flush = 1'b0;
        withhold    = 1'b1;
        run_cycles(40);
        mark = delivered;
        run_cycles(20);
        assert (delivered == mark) else report_failure("delivery went on with no credits left");
        assert (!fetch_req) else report_failure("fetch did not stop with the buffer full");
        withhold = 1'b0;
        run_cycles(200);
        assert (delivered > 100) else report_failure("too few instructions were delivered");

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if ((mismatches + failures) == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

/* hdl/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top
    import pipeline_types::*;
#(
    parameter int BTB_INDEX_BITS  = 4,
    parameter int BUF_DEPTH       = 8,
    parameter int BACKEND_CREDITS = 4
) (
    input  logic  clk,
    input  logic  rst,

    // Instruction cache
    output addr_t fetch_pc,
    output logic  fetch_req,
    input  inst_t icache_inst,
    input  logic  icache_valid,
    input  logic  icache_stall,

    // Branch update and redirect
    input  logic  upd_valid,
    input  addr_t upd_pc,
    input  logic  upd_taken,
    input  addr_t upd_target,
    input  logic  flush,

    // Backend delivery
    input  logic  credit_return,
    output logic  out_valid,
    output addr_t out_pc,
    output inst_t out_inst,
    output logic  out_pred_taken,
    output addr_t out_pred_target
);

    predict_if pred_bus ();
    update_if  upd_bus ();

    assign fetch_pc  = pred_bus.fetch_pc;
    assign fetch_req = pred_bus.fetch_req;

    assign upd_bus.upd_valid  = upd_valid;
    assign upd_bus.upd_pc     = upd_pc;
    assign upd_bus.upd_taken  = upd_taken;
    assign upd_bus.upd_target = upd_target;
    assign upd_bus.flush      = flush;

    pc_reg u_pc_reg (
        .clk,
        .rst,
        .icache_stall,
        .pred (pred_bus.pc_side),
        .upd  (upd_bus.pc_side)
    );

    bpu #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_bpu (
        .clk,
        .rst,
        .pred (pred_bus.bpu_side),
        .upd  (upd_bus.bpu_side)
    );

    instbuffer #(
        .BUF_DEPTH       (BUF_DEPTH),
        .BACKEND_CREDITS (BACKEND_CREDITS)
    ) u_instbuffer (
        .clk,
        .rst,
        .icache_inst,
        .icache_valid,
        .credit_return,
        .pred (pred_bus.buf_side),
        .upd  (upd_bus.buf_side),
        .out_valid,
        .out_pc,
        .out_inst,
        .out_pred_taken,
        .out_pred_target
    );

endmodule

/* hdl/instbuffer.sv */
`timescale 1ns/1ps

module instbuffer
    import pipeline_types::*;
#(
    parameter int BUF_DEPTH       = 8,
    parameter int BACKEND_CREDITS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  inst_t       icache_inst,
    input  logic        icache_valid,
    input  logic        credit_return,
    predict_if.buf_side pred,
    update_if.buf_side  upd,
    output logic        out_valid,
    output addr_t       out_pc,
    output inst_t       out_inst,
    output logic        out_pred_taken,
    output addr_t       out_pred_target
);

    localparam int PTR_BITS = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(BUF_DEPTH + 1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] count_t;

    // Tag stage for the fetch now in flight
    addr_t tag_pc;
    logic  tag_taken;
    addr_t tag_target;
    logic  drop_return;

    fetch_entry_t mem [BUF_DEPTH];
    fetch_entry_t out_entry;
    ptr_t         wr_ptr;
    ptr_t         rd_ptr;
    count_t       count;
    credit_t      credit;
    logic         wr_en;
    logic         rd_en;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (pred.fetch_req) begin
            tag_pc     <= pred.fetch_pc;
            tag_taken  <= pred.pred_taken;
            tag_target <= pred.pred_target;
        end
    end

    // Return of the fetch issued during a flush is thrown away
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_return <= 1'b0;
        end else begin
            drop_return <= upd.flush;
        end
    end

    //////////////////////////////
    // FIFO control
    //////////////////////////////

    assign wr_en = icache_valid && !drop_return && !upd.flush;
    assign rd_en = (count != '0) && (credit != '0) && !upd.flush;

    // Room for the fetch in flight plus one more
    assign pred.buf_ready = (count_t'(BUF_DEPTH) - count) >= 2;

    always_ff @(posedge clk) begin
        if (rst || upd.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + count_t'(wr_en) - count_t'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= credit_t'(BACKEND_CREDITS);
        end else begin
            credit <= credit - credit_t'(rd_en) + credit_t'(credit_return);
        end
    end

    //////////////////////////////
    // Storage and output stage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= '{pc: tag_pc, inst: icache_inst,
                             pred_taken: tag_taken, pred_target: tag_target};
        end
        if (rd_en) begin
            out_entry <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    assign out_pc          = out_entry.pc;
    assign out_inst        = out_entry.inst;
    assign out_pred_taken  = out_entry.pred_taken;
    assign out_pred_target = out_entry.pred_target;

    // Fetch throttling in pc_reg keeps the queue from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> count < BUF_DEPTH);

    // Backend never returns more than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credit <= BACKEND_CREDITS);

endmodule

/* hdl/bpu.sv */
`timescale 1ns/1ps

module bpu
    import pipeline_types::*;
#(
    parameter int BTB_INDEX_BITS = 4
) (
    input logic         clk,
    input logic         rst,
    predict_if.bpu_side pred,
    update_if.bpu_side  upd
);

    localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
    localparam int TAG_BITS = 32 - BTB_INDEX_BITS - 2;

    typedef logic [BTB_INDEX_BITS-1:0] btb_idx_t;
    typedef logic [TAG_BITS-1:0]       btb_tag_t;

    //////////////////////////////
    // BTB storage
    //////////////////////////////

    logic     btb_valid  [ENTRIES];
    btb_tag_t btb_tag    [ENTRIES];
    addr_t    btb_target [ENTRIES];
    counter_t btb_ctr    [ENTRIES];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    logic     rd_hit;
    btb_idx_t wr_idx;
    btb_tag_t wr_tag;
    logic     wr_hit;

    //////////////////////////////
    // Lookup
    //////////////////////////////

    assign rd_idx = pred.fetch_pc[BTB_INDEX_BITS+1:2];
    assign rd_tag = pred.fetch_pc[31:BTB_INDEX_BITS+2];
    assign rd_hit = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);

    assign pred.pred_taken = rd_hit && (btb_ctr[rd_idx] >= CTR_WEAK_TAKEN);

    // Target of the indexed entry, used only when predicted taken
    assign pred.pred_target = btb_target[rd_idx];

    //////////////////////////////
    // Training
    //////////////////////////////

    assign wr_idx = upd.upd_pc[BTB_INDEX_BITS+1:2];
    assign wr_tag = upd.upd_pc[31:BTB_INDEX_BITS+2];
    assign wr_hit = btb_valid[wr_idx] && (btb_tag[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (upd.upd_valid && upd.upd_taken) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.upd_valid) begin
            if (upd.upd_taken) begin
                btb_tag[wr_idx]    <= wr_tag;
                btb_target[wr_idx] <= upd.upd_target;
                if (!wr_hit) begin
                    // New or replaced entry starts weakly taken
                    btb_ctr[wr_idx] <= CTR_WEAK_TAKEN;
                end else if (btb_ctr[wr_idx] != CTR_MAX) begin
                    btb_ctr[wr_idx] <= btb_ctr[wr_idx] + 2'd1;
                end
            end else if (wr_hit && (btb_ctr[wr_idx] != CTR_MIN)) begin
                btb_ctr[wr_idx] <= btb_ctr[wr_idx] - 2'd1;
            end
        end
    end

endmodule

/* hdl/pc_reg.sv */
`timescale 1ns/1ps

module pc_reg
    import pipeline_types::*;
(
    input logic        clk,
    input logic        rst,
    input logic        icache_stall,
    predict_if.pc_side pred,
    update_if.pc_side  upd
);

    fetch_state_e state;
    fetch_state_e state_next;
    addr_t        pc_next;
    logic         issue;

    // Bubble after reset and after every flush
    assign pred.fetch_req = (state != FETCH_DRAIN) && pred.buf_ready;
    assign issue = pred.fetch_req && !icache_stall;

    //////////////////////////////
    // Next PC and state
    //////////////////////////////

    always_comb begin
        pc_next    = pred.fetch_pc;
        state_next = state;
        if (upd.flush) begin
            pc_next    = upd.upd_target;
            state_next = FETCH_DRAIN;
        end else begin
            case (state)
                FETCH_DRAIN: begin
                    state_next = FETCH_RUN;
                end
                FETCH_RUN, FETCH_HOLD: begin
                    if (issue) begin
                        state_next = FETCH_RUN;
                        pc_next = pred.pred_taken ? pred.pred_target
                                                  : pred.fetch_pc + PC_STEP;
                    end else if (pred.fetch_req) begin
                        // Cache busy, request held for retry
                        state_next = FETCH_HOLD;
                    end else begin
                        state_next = FETCH_RUN;
                    end
                end
                default: begin
                    state_next = FETCH_RUN;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= FETCH_DRAIN;
            pred.fetch_pc <= PC_RESET;
        end else begin
            state         <= state_next;
            pred.fetch_pc <= pc_next;
        end
    end

    // Fetch addresses stay word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pred.fetch_pc[1:0] == 2'b00);

endmodule

/* hdl/update_if.sv */
`timescale 1ns/1ps

interface update_if
    import pipeline_types::*;
();

    // Resolved branch from the backend
    logic  upd_valid;
    addr_t upd_pc;
    logic  upd_taken;
    addr_t upd_target;

    // Redirect, target travels in upd_target
    logic  flush;

    modport bpu_side (
        input upd_valid, upd_pc, upd_taken, upd_target
    );

    modport pc_side (
        input flush, upd_target
    );

    modport buf_side (
        input flush
    );

endinterface

/* hdl/predict_if.sv */
`timescale 1ns/1ps

interface predict_if
    import pipeline_types::*;
();

    // Fetch request toward the cache
    addr_t fetch_pc;
    logic  fetch_req;

    // BTB answer for fetch_pc in the same cycle
    logic  pred_taken;
    addr_t pred_target;

    // Two or more free buffer slots
    logic  buf_ready;

    modport pc_side (
        output fetch_pc, fetch_req,
        input  pred_taken, pred_target, buf_ready
    );

    modport bpu_side (
        input  fetch_pc,
        output pred_taken, pred_target
    );

    modport buf_side (
        input  fetch_pc, fetch_req, pred_taken, pred_target,
        output buf_ready
    );

endinterface

/* hdl/pipeline_types.sv */
package pipeline_types;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    // Byte address of an instruction
    typedef logic [31:0] addr_t;

    // Raw 32-bit instruction word
    typedef logic [31:0] inst_t;

    // Saturating direction counter, taken from 2 upward
    typedef logic [1:0] counter_t;

    // Credits held toward the backend
    typedef logic [3:0] credit_t;

    //////////////////////////////
    // Constants
    //////////////////////////////

    // First fetch address out of reset
    localparam addr_t PC_RESET = 32'h0000_1000;

    // Sequential step for one instruction
    localparam addr_t PC_STEP = 32'd4;

    // Direction counter levels
    localparam counter_t CTR_MIN        = 2'd0;
    localparam counter_t CTR_WEAK_TAKEN = 2'd2;
    localparam counter_t CTR_MAX        = 2'd3;

    //////////////////////////////
    // Fetch control
    //////////////////////////////

    typedef enum logic [1:0] {
        FETCH_RUN   = 2'd0,
        FETCH_HOLD  = 2'd1,
        FETCH_DRAIN = 2'd2
    } fetch_state_e;

    // One queued instruction together with its prediction
    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  pred_taken;
        addr_t pred_target;
    } fetch_entry_t;

endpackage
